// ==== Bender.yml ====
package:
  name: mgmt_core

export_include_dirs:
  - .

sources:
  - files:
      - hk_pkg.sv
      - clk_pkg.sv
      - hk_spi_rx.sv
      - hk_regs.sv
      - hk_spi_tx.sv
      - mgmt_clocking.sv
      - mgmt_core.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_mgmt_core.sv

// ==== clk_pkg.sv ====
//############################
// Clocking block types
// Divider state, reset sequencer state
//############################

`default_nettype none

package clk_pkg;

	// User clock divider
	typedef enum logic {
		CLK_OFF = 1'b0,
		CLK_RUN = 1'b1
	} clk_state_e;

	// Core reset sequencer
	// HOLD keeps reset asserted, SYNC walks the release through the chain
	typedef enum logic [1:0] {
		RST_HOLD = 2'b00,
		RST_SYNC = 2'b01,
		RST_RUN  = 2'b10
	} rst_state_e;

endpackage

`default_nettype wire

// ==== hk_pkg.sv ====
//############################
// Housekeeping SPI types
// Opcodes, receiver states, register map
//############################

`include "mgmt_core_defines.svh"
`default_nettype none

package hk_pkg;

	// Opcode in the two top bits of the command byte
	typedef enum logic [1:0] {
		HK_OP_NOP   = 2'b00,
		HK_OP_READ  = 2'b01,
		HK_OP_WRITE = 2'b10
	} hk_op_e;

	// Frame state of the SPI receiver
	typedef enum logic [1:0] {
		HK_ST_IDLE = 2'b00,
		HK_ST_CMD  = 2'b01,
		HK_ST_DATA = 2'b10,
		HK_ST_DONE = 2'b11
	} hk_state_e;

	// Register map, low six bits of the command byte
	typedef enum logic [`MGMT_ADDR_W-1:0] {
		HK_REG_MASK_REV = 6'h03,
		HK_REG_CTRL     = 6'h08,
		HK_REG_DIV      = 6'h11,
		HK_REG_SCRATCH  = 6'h20
	} hk_reg_e;

endpackage

`default_nettype wire

// ==== hk_regs.sv ====
//############################
// Housekeeping register file
// CTRL, DIV, SCRATCH, read mux
//############################

`timescale 1ns/1ns
`include "mgmt_core_defines.svh"
`default_nettype none

module hk_regs (
	input  wire                     clock,
	input  wire                     arst_n_i,
	// Write port from the SPI receiver
	input  wire                     wr_stb_i,
	input  wire hk_pkg::hk_reg_e    wr_addr_i,
	input  wire [`MGMT_DATA_W-1:0]  wr_data_i,
	// Read port
	input  wire                     rd_stb_i,
	input  wire hk_pkg::hk_reg_e    rd_addr_i,
	// Metal programmed mask revision
	input  wire [31:0]              mask_rev_i,
	output logic [`MGMT_DATA_W-1:0] rd_data_o,
	// Levels to the clocking block
	output logic                    pll_ena_o,
	output logic                    soft_rst_o,
	output logic [`MGMT_DIV_W-1:0]  pll_div_o
);
	import hk_pkg::*;

	// CTRL bit 0 pll enable, bit 1 soft reset
	logic [1:0]              ctrl_q;
	logic [`MGMT_DIV_W-1:0]  div_q;
	logic [`MGMT_DATA_W-1:0] scratch_q;
	logic [`MGMT_DATA_W-1:0] rd_mux;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q    <= 2'b00;
			div_q     <= `MGMT_DIV_W'd4;
			scratch_q <= '0;
		end else if (wr_stb_i) begin
			case (wr_addr_i)
			HK_REG_CTRL:    ctrl_q    <= wr_data_i[1:0];
			HK_REG_DIV:     div_q     <= wr_data_i[`MGMT_DIV_W-1:0];
			HK_REG_SCRATCH: scratch_q <= wr_data_i;
			// MASK_REV is read-only, unknown addresses drop the write
			default: ;
			endcase
		end
	end

	// Unused bits read as zero
	always_comb begin
		case (rd_addr_i)
		HK_REG_CTRL:     rd_mux = {{(`MGMT_DATA_W-2){1'b0}}, ctrl_q};
		HK_REG_DIV:      rd_mux = {{(`MGMT_DATA_W-`MGMT_DIV_W){1'b0}}, div_q};
		HK_REG_MASK_REV: rd_mux = mask_rev_i[`MGMT_DATA_W-1:0];
		HK_REG_SCRATCH:  rd_mux = scratch_q;
		default:         rd_mux = '0;
		endcase
	end

	// Read data is valid the cycle after rd_stb
	always_ff @(posedge clock) begin
		if (rd_stb_i) begin
			rd_data_o <= rd_mux;
		end
	end

	assign pll_ena_o  = ctrl_q[0];
	assign soft_rst_o = ctrl_q[1];
	assign pll_div_o  = div_q;

endmodule

`default_nettype wire

// ==== hk_spi_rx.sv ====
//############################
// Housekeeping SPI receiver
// Pin synchronizers, SCK edge detect, frame FSM
//############################

`timescale 1ns/1ns
`include "mgmt_core_defines.svh"
`default_nettype none

module hk_spi_rx (
	input  wire                     clock,
	input  wire                     arst_n_i,
	// SPI pins, mode 0
	input  wire                     sck_i,
	input  wire                     csb_i,
	input  wire                     sdi_i,
	// Register write request
	output logic                    wr_stb_o,
	output hk_pkg::hk_reg_e         wr_addr_o,
	output logic [`MGMT_DATA_W-1:0] wr_data_o,
	// Register read request
	output logic                    rd_stb_o,
	output hk_pkg::hk_reg_e         rd_addr_o,
	// Synchronized SCK fall and CSB for the SDO shifter
	output logic                    sck_fall_o,
	output logic                    csb_o
);
	import hk_pkg::*;

	localparam int unsigned SYNC_N = `MGMT_SYNC_STAGES;

	// One chain for all three pins, bit 2 SCK, bit 1 CSB, bit 0 SDI
	logic [SYNC_N-1:0][2:0]  pin_sync;
	logic                    sck_s;
	logic                    csb_s;
	logic                    sdi_s;
	logic                    sck_q;
	logic                    sck_rise;
	hk_state_e               state_q;
	hk_op_e                  op_q;
	logic [3:0]              bit_cnt_q;
	logic [`MGMT_DATA_W-2:0] shift_q;
	hk_reg_e                 addr_q;
	logic                    cmd_done;
	logic                    frame_done;

	assign sck_s = pin_sync[SYNC_N-1][2];
	assign csb_s = pin_sync[SYNC_N-1][1];
	assign sdi_s = pin_sync[SYNC_N-1][0];

	// CSB idles high out of reset
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pin_sync <= {SYNC_N{3'b010}};
			sck_q    <= 1'b0;
		end else begin
			pin_sync <= {pin_sync[SYNC_N-2:0], {sck_i, csb_i, sdi_i}};
			sck_q    <= sck_s;
		end
	end

	// Edges of the synchronized SCK
	assign sck_rise   = sck_s & ~sck_q;
	assign sck_fall_o = ~sck_s & sck_q;
	assign csb_o      = csb_s;

	// 8th rise closes the command byte, 16th rise the data byte
	assign cmd_done   = !csb_s && (state_q == HK_ST_CMD) && sck_rise && (bit_cnt_q == 4'd7);
	assign frame_done = !csb_s && (state_q == HK_ST_DATA) && sck_rise && (bit_cnt_q == 4'd15);

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= HK_ST_IDLE;
			op_q      <= HK_OP_NOP;
			bit_cnt_q <= '0;
			wr_stb_o  <= 1'b0;
			rd_stb_o  <= 1'b0;
		end else begin
			wr_stb_o <= 1'b0;
			rd_stb_o <= 1'b0;
			// CSB high drops any frame in progress, no strobe
			if (csb_s) begin
				state_q <= HK_ST_IDLE;
			end else begin
				case (state_q)
				HK_ST_IDLE: begin
					bit_cnt_q <= '0;
					state_q   <= HK_ST_CMD;
				end
				HK_ST_CMD: begin
					if (sck_rise) begin
						bit_cnt_q <= bit_cnt_q + 4'd1;
					end
					// Opcode sits in the two oldest bits of the shifter
					if (cmd_done) begin
						op_q     <= hk_op_e'(shift_q[`MGMT_DATA_W-2 -: 2]);
						rd_stb_o <= (shift_q[`MGMT_DATA_W-2 -: 2] == HK_OP_READ);
						state_q  <= HK_ST_DATA;
					end
				end
				HK_ST_DATA: begin
					if (sck_rise) begin
						bit_cnt_q <= bit_cnt_q + 4'd1;
					end
					if (frame_done) begin
						wr_stb_o <= (op_q == HK_OP_WRITE);
						state_q  <= HK_ST_DONE;
					end
				end
				HK_ST_DONE: begin
					// Extra SCK edges are ignored until CSB rises
					state_q <= HK_ST_DONE;
				end
				default: state_q <= HK_ST_IDLE;
				endcase
			end
		end
	end

	// Shift register and captured fields
	always_ff @(posedge clock) begin
		if (sck_rise) begin
			shift_q <= {shift_q[`MGMT_DATA_W-3:0], sdi_s};
		end
		if (cmd_done) begin
			addr_q <= hk_reg_e'({shift_q[`MGMT_ADDR_W-2:0], sdi_s});
		end
		if (frame_done) begin
			wr_data_o <= {shift_q, sdi_s};
		end
	end

	assign wr_addr_o = addr_q;
	assign rd_addr_o = addr_q;

	// A frame asks for a read or a write, never both at once
	a_stb_excl: assert property (@(posedge clock) disable iff (!arst_n_i)
		!(wr_stb_o && rd_stb_o));
	a_wr_pulse: assert property (@(posedge clock) disable iff (!arst_n_i)
		wr_stb_o |=> !wr_stb_o);
	a_rd_pulse: assert property (@(posedge clock) disable iff (!arst_n_i)
		rd_stb_o |=> !rd_stb_o);

endmodule

`default_nettype wire

// ==== hk_spi_tx.sv ====
//############################
// Housekeeping SDO shifter
// Read byte output and SDO enable
//############################

`timescale 1ns/1ns
`include "mgmt_core_defines.svh"
`default_nettype none

module hk_spi_tx (
	input  wire                    clock,
	input  wire                    arst_n_i,
	input  wire                    rd_stb_i,
	input  wire [`MGMT_DATA_W-1:0] rd_data_i,
	// Synchronized SPI timing from the receiver
	input  wire                    sck_fall_i,
	input  wire                    csb_i,
	output logic                   sdo_o,
	output logic                   sdo_outenb_o
);

	logic                    load_q;
	logic                    skip_q;
	logic                    oenb_q;
	logic [`MGMT_DATA_W-1:0] shift_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			load_q  <= 1'b0;
			skip_q  <= 1'b0;
			oenb_q  <= 1'b1;
			shift_q <= '0;
		end else begin
			// Register file answers one cycle after the strobe
			load_q <= rd_stb_i;
			// Drive SDO from the read request until the frame ends
			if (csb_i) begin
				oenb_q <= 1'b1;
			end else if (rd_stb_i) begin
				oenb_q <= 1'b0;
			end
			if (load_q) begin
				shift_q <= rd_data_i;
				skip_q  <= 1'b1;
			end else if (csb_i) begin
				shift_q <= '0;
			end else if (sck_fall_i && !oenb_q) begin
				// First fall after the command byte is where mode 0 shows the MSB
				if (skip_q) begin
					skip_q <= 1'b0;
				end else begin
					shift_q <= {shift_q[`MGMT_DATA_W-2:0], 1'b0};
				end
			end
		end
	end

	assign sdo_o        = shift_q[`MGMT_DATA_W-1];
	assign sdo_outenb_o = oenb_q;

endmodule

`default_nettype wire

// ==== mgmt_clocking.sv ====
//############################
// Clocking block
// User clock divider, core reset sequencer
//############################

`timescale 1ns/1ns
`include "mgmt_core_defines.svh"
`default_nettype none

module mgmt_clocking (
	input  wire                    clock,
	input  wire                    arst_n_i,
	input  wire                    pll_ena_i,
	input  wire                    soft_rst_i,
	input  wire [`MGMT_DIV_W-1:0]  pll_div_i,
	output logic                   user_clk_o,
	output logic                   core_rstn_o
);
	import clk_pkg::*;

	localparam int unsigned SYNC_N = `MGMT_SYNC_STAGES;

	clk_state_e             clk_st_q;
	logic [`MGMT_DIV_W-1:0] cnt_q;
	logic                   run_ok;
	rst_state_e             rst_st_q;
	logic [SYNC_N-1:0]      rst_sync_q;

	// Divide by zero means no clock
	assign run_ok = pll_ena_i && (pll_div_i != '0);

	// Half period of pll_div cycles
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clk_st_q   <= CLK_OFF;
			cnt_q      <= '0;
			user_clk_o <= 1'b0;
		end else if (!run_ok) begin
			clk_st_q   <= CLK_OFF;
			cnt_q      <= '0;
			user_clk_o <= 1'b0;
		end else if (clk_st_q == CLK_OFF) begin
			clk_st_q <= CLK_RUN;
		end else if (cnt_q >= pll_div_i - `MGMT_DIV_W'd1) begin
			// Also catches a divider lowered below the running count
			cnt_q      <= '0;
			user_clk_o <= ~user_clk_o;
		end else begin
			cnt_q <= cnt_q + `MGMT_DIV_W'd1;
		end
	end

	// Release ripples through the chain, assert is immediate
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_st_q   <= RST_HOLD;
			rst_sync_q <= '0;
		end else if (soft_rst_i) begin
			rst_st_q   <= RST_HOLD;
			rst_sync_q <= '0;
		end else if (rst_st_q != RST_RUN) begin
			rst_sync_q <= {rst_sync_q[SYNC_N-2:0], 1'b1};
			rst_st_q   <= rst_sync_q[SYNC_N-2] ? RST_RUN : RST_SYNC;
		end
	end

	assign core_rstn_o = rst_sync_q[SYNC_N-1];

	// User clock is held low while the divider is off
	a_off_low: assert property (@(posedge clock) disable iff (!arst_n_i)
		(clk_st_q == CLK_OFF) |-> !user_clk_o);

endmodule

`default_nettype wire

// ==== mgmt_core.f ====
+incdir+.
hk_pkg.sv
clk_pkg.sv
hk_spi_rx.sv
hk_regs.sv
hk_spi_tx.sv
mgmt_clocking.sv
mgmt_core.sv
tb_clk_gen.sv
tb_checker.sv
tb_mgmt_core.sv

// ==== mgmt_core.sv ====
//############################
// Management core top
// SPI receiver, registers, SDO, clocking
//############################

`timescale 1ns/1ns
`include "mgmt_core_defines.svh"
`default_nettype none

module mgmt_core (
	input  wire        clock,
	input  wire        arst_n_i,
	// Housekeeping SPI
	input  wire        sck_i,
	input  wire        csb_i,
	input  wire        sdi_i,
	output logic       sdo_o,
	output logic       sdo_outenb_o,
	// Metal programmed mask revision
	input  wire [31:0] mask_rev_i,
	// Clocking
	output logic       user_clk_o,
	output logic       core_rstn_o
);
	import hk_pkg::*;

	wire                    wr_stb;
	hk_reg_e                wr_addr;
	wire [`MGMT_DATA_W-1:0] wr_data;
	wire                    rd_stb;
	hk_reg_e                rd_addr;
	wire [`MGMT_DATA_W-1:0] rd_data;
	wire                    sck_fall;
	wire                    csb_s;
	wire                    pll_ena;
	wire                    soft_rst;
	wire [`MGMT_DIV_W-1:0]  pll_div;

	// Frame deserializer
	hk_spi_rx i_hk_spi_rx (
		.clock      (clock),
		.arst_n_i   (arst_n_i),
		.sck_i      (sck_i),
		.csb_i      (csb_i),
		.sdi_i      (sdi_i),
		.wr_stb_o   (wr_stb),
		.wr_addr_o  (wr_addr),
		.wr_data_o  (wr_data),
		.rd_stb_o   (rd_stb),
		.rd_addr_o  (rd_addr),
		.sck_fall_o (sck_fall),
		.csb_o      (csb_s)
	);

	hk_regs i_hk_regs (
		.clock      (clock),
		.arst_n_i   (arst_n_i),
		.wr_stb_i   (wr_stb),
		.wr_addr_i  (wr_addr),
		.wr_data_i  (wr_data),
		.rd_stb_i   (rd_stb),
		.rd_addr_i  (rd_addr),
		.mask_rev_i (mask_rev_i),
		.rd_data_o  (rd_data),
		.pll_ena_o  (pll_ena),
		.soft_rst_o (soft_rst),
		.pll_div_o  (pll_div)
	);

	// SDO side runs off the synchronized SCK and CSB
	hk_spi_tx i_hk_spi_tx (
		.clock        (clock),
		.arst_n_i     (arst_n_i),
		.rd_stb_i     (rd_stb),
		.rd_data_i    (rd_data),
		.sck_fall_i   (sck_fall),
		.csb_i        (csb_s),
		.sdo_o        (sdo_o),
		.sdo_outenb_o (sdo_outenb_o)
	);

	mgmt_clocking i_mgmt_clocking (
		.clock       (clock),
		.arst_n_i    (arst_n_i),
		.pll_ena_i   (pll_ena),
		.soft_rst_i  (soft_rst),
		.pll_div_i   (pll_div),
		.user_clk_o  (user_clk_o),
		.core_rstn_o (core_rstn_o)
	);

endmodule

`default_nettype wire

// ==== mgmt_core_defines.svh ====
//############################
// Shared width and depth macros
// Address, data and divider widths, synchronizer depth
//############################

`default_nettype none

`ifndef MGMT_CORE_DEFINES_SVH
`define MGMT_CORE_DEFINES_SVH

// Housekeeping register address width
`define MGMT_ADDR_W 6

// Housekeeping register data width
`define MGMT_DATA_W 8

// Width of the user clock divider field
`define MGMT_DIV_W 5

// Flops per synchronizer chain
`define MGMT_SYNC_STAGES 2

`endif

`default_nettype wire

// ==== tb_checker.sv ====
//############################
// Testbench checker
// Register model, SDO compare, clock and reset checks
//############################

`timescale 1ns/1ns
`default_nettype none

module tb_checker (
	input  wire        clock,
	input  wire        arst_n_i,
	input  wire        sck_i,
	input  wire        csb_i,
	input  wire        sdi_i,
	input  wire [31:0] mask_rev_i,
	input  wire        sdo_i,
	input  wire        sdo_outenb_i,
	input  wire        user_clk_i,
	input  wire        core_rstn_i
);
	import hk_pkg::*;

	int          n_checks = 0;
	int          n_errors = 0;
	int          n_tests  = 0;
	int          test_err = 0;
	// Model of CTRL, DIV and SCRATCH
	logic [1:0]  ctrl_m    = 2'b00;
	logic [4:0]  div_m     = 5'd4;
	logic [7:0]  scratch_m = 8'h00;
	// Frame capture at the pins
	int          fr_cnt = 0;
	logic [15:0] fr_bits;
	logic [1:0]  op_cap;
	logic [5:0]  addr_cap;
	logic [7:0]  rd_byte;

	// Expected read value from the register map
	function automatic logic [7:0] ref_read(input logic [5:0] addr);
		case (addr)
		HK_REG_CTRL:     return {6'b0, ctrl_m};
		HK_REG_DIV:      return {3'b0, div_m};
		HK_REG_MASK_REV: return mask_rev_i[7:0];
		HK_REG_SCRATCH:  return scratch_m;
		default:         return 8'h00;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_err++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic fail_note(input string what);
		n_checks++;
		n_errors++;
		test_err++;
		$display("FAIL %s", what);
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (test_err == 0)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, test_err);
		test_err = 0;
	endtask

	task automatic report_counts();
		$display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
	endtask

	// Model resets with the core
	always @(negedge arst_n_i) begin
		ctrl_m    = 2'b00;
		div_m     = 5'd4;
		scratch_m = 8'h00;
	end

	always @(negedge csb_i) begin
		fr_cnt  = 0;
		fr_bits = '0;
	end

	// Pins are stable here, the driver moved SDI many cycles before
	always @(posedge sck_i) begin
		if (!csb_i && fr_cnt < 16) begin
			fr_bits = {fr_bits[14:0], sdi_i};
			fr_cnt++;
			if (fr_cnt == 8) begin
				op_cap   = fr_bits[7:6];
				addr_cap = fr_bits[5:0];
			end else if (fr_cnt > 8 && op_cap == HK_OP_READ) begin
				rd_byte = {rd_byte[6:0], sdo_i};
				check_val("sdo_outenb_o", sdo_outenb_i, 1'b0);
			end
		end
	end

	// Only a full 16 bit frame counts
	always @(posedge csb_i) begin
		if (fr_cnt == 16) begin
			if (op_cap == HK_OP_WRITE) begin
				case (addr_cap)
				HK_REG_CTRL:    ctrl_m    = fr_bits[1:0];
				HK_REG_DIV:     div_m     = fr_bits[4:0];
				HK_REG_SCRATCH: scratch_m = fr_bits[7:0];
				default: ;
				endcase
			end else if (op_cap == HK_OP_READ) begin
				check_val($sformatf("sdo_o addr %h", addr_cap), rd_byte,
					ref_read(addr_cap));
			end
		end
		fr_cnt = 0;
	end

	// Waits for a user_clk_o edge, then counts cycles to the next one
	task automatic measure_half(input int exp);
		logic v;
		int   n;
		int   k;
		@(negedge clock);
		for (k = 0; k < 2; k++) begin
			v = user_clk_i;
			n = 0;
			while (user_clk_i === v && n < 200) begin
				@(negedge clock);
				n++;
			end
			if (n >= 200) begin
				fail_note("user_clk_o did not toggle");
				return;
			end
			// First pass only aligns to an edge
			if (k == 1)
				check_val("user_clk_o half period", n, exp);
		end
	endtask

	task automatic expect_clk_low(input int cycles);
		int i;
		for (i = 0; i < cycles; i++) begin
			@(negedge clock);
			if (user_clk_i !== 1'b0) begin
				check_val("user_clk_o", user_clk_i, 1'b0);
				return;
			end
		end
	endtask

	// Cycles until core_rstn_o reaches val, fails after limit
	task automatic wait_rstn(input logic val, input int limit, output int n);
		n = 0;
		while (core_rstn_i !== val && n < limit) begin
			@(negedge clock);
			n++;
		end
		if (core_rstn_i !== val)
			fail_note($sformatf("core_rstn_o did not reach %b in %0d cycles", val, limit));
	endtask

	// Cycles until sdo_outenb_o reaches val, fails after limit
	task automatic wait_oenb(input logic val, input int limit, output int n);
		n = 0;
		while (sdo_outenb_i !== val && n < limit) begin
			@(negedge clock);
			n++;
		end
		if (sdo_outenb_i !== val)
			fail_note($sformatf("sdo_outenb_o did not reach %b in %0d cycles", val, limit));
	endtask

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
//############################
// Testbench clock and reset
//############################

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int unsigned PERIOD_NS  = 100,
	parameter int unsigned RST_CYCLES = 16
) (
	output logic clock,
	output logic arst_n_o
);

	initial begin
		clock    = 1'b0;
		arst_n_o = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		repeat (RST_CYCLES) @(posedge clock);
		@(negedge clock);
		arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_mgmt_core.sv ====
//############################
// Testbench top
// DUT, SPI frame driver, LFSR, test sequence
//############################

`timescale 1ns/1ns
`default_nettype none

module tb_mgmt_core;
	import hk_pkg::*;

	logic        clock;
	logic        arst_n;
	logic        sck;
	logic        csb;
	logic        sdi;
	logic [31:0] mask_rev;
	wire         sdo;
	wire         sdo_outenb;
	wire         user_clk;
	wire         core_rstn;
	logic [31:0] lfsr = 32'hc7aa7f39;
	logic [31:0] rv;
	int          n;
	int          i;

	tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(16)) i_clk_gen (
		.clock    (clock),
		.arst_n_o (arst_n)
	);

	mgmt_core i_mgmt_core (
		.clock        (clock),
		.arst_n_i     (arst_n),
		.sck_i        (sck),
		.csb_i        (csb),
		.sdi_i        (sdi),
		.sdo_o        (sdo),
		.sdo_outenb_o (sdo_outenb),
		.mask_rev_i   (mask_rev),
		.user_clk_o   (user_clk),
		.core_rstn_o  (core_rstn)
	);

	tb_checker i_checker (
		.clock        (clock),
		.arst_n_i     (arst_n),
		.sck_i        (sck),
		.csb_i        (csb),
		.sdi_i        (sdi),
		.mask_rev_i   (mask_rev),
		.sdo_i        (sdo),
		.sdo_outenb_i (sdo_outenb),
		.user_clk_i   (user_clk),
		.core_rstn_i  (core_rstn)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int nb, output logic [31:0] v);
		int k;
		v = '0;
		for (k = 0; k < nb; k++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Mode 0, MSB first, each SCK level held 6 cycles
	task automatic spi_frame(input logic [1:0] op, input logic [5:0] addr,
		input logic [7:0] data, input int nbits);
		logic [15:0] word;
		int          b;
		word = {op, addr, data};
		@(negedge clock);
		csb = 1'b0;
		for (b = 0; b < nbits; b++) begin
			sdi = word[15 - b];
			repeat (6) @(negedge clock);
			sck = 1'b1;
			repeat (6) @(negedge clock);
			sck = 1'b0;
		end
		repeat (6) @(negedge clock);
		csb = 1'b1;
		sdi = 1'b0;
		repeat (8) @(negedge clock);
	endtask

	task automatic spi_write(input logic [5:0] addr, input logic [7:0] data);
		spi_frame(HK_OP_WRITE, addr, data, 16);
	endtask

	task automatic spi_read(input logic [5:0] addr);
		spi_frame(HK_OP_READ, addr, 8'h00, 16);
	endtask

	// Watchdog against a hung run
	initial begin
		#50ms;
		$display("Simulation stopped by the watchdog");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		sck      = 1'b0;
		csb      = 1'b1;
		sdi      = 1'b0;
		mask_rev = 32'h0000_0000;
		rand_bits(32, rv);
		mask_rev = rv;
		// Release lands on a falling edge, seen at the next rising edge
		n = 0;
		while (arst_n !== 1'b1 && n < 40) begin
			@(posedge clock);
			n++;
		end
		if (arst_n !== 1'b1)
			i_checker.fail_note("reset was not released");

		// Reset values
		i_checker.wait_rstn(1'b1, 10, n);
		i_checker.check_val("core_rstn_o release cycles", n, 2);
		i_checker.check_val("sdo_outenb_o", sdo_outenb, 1'b1);
		i_checker.check_val("user_clk_o", user_clk, 1'b0);
		i_checker.check_val("sdo_o", sdo, 1'b0);
		spi_read(HK_REG_CTRL);
		spi_read(HK_REG_DIV);
		spi_read(HK_REG_SCRATCH);
		i_checker.end_test("reset");

		// Random write and read back
		for (i = 0; i < 4; i++) begin
			rand_bits(8, rv);
			spi_write(HK_REG_SCRATCH, rv[7:0]);
			spi_read(HK_REG_SCRATCH);
			rand_bits(8, rv);
			spi_write(HK_REG_DIV, rv[7:0]);
			spi_read(HK_REG_DIV);
		end
		i_checker.end_test("write_read");

		// Mask revision and unknown addresses
		spi_read(HK_REG_MASK_REV);
		spi_write(HK_REG_MASK_REV, ~mask_rev[7:0]);
		spi_read(HK_REG_MASK_REV);
		spi_write(6'h3f, 8'h5a);
		spi_read(6'h3f);
		spi_read(6'h01);
		i_checker.end_test("mask_rev");

		// User clock divider
		rand_bits(5, rv);
		if (rv[4:0] == 5'd0)
			rv = 32'd3;
		spi_write(HK_REG_DIV, rv[7:0]);
		spi_write(HK_REG_CTRL, 8'h01);
		i_checker.measure_half(rv[4:0]);
		spi_write(HK_REG_DIV, 8'h02);
		i_checker.measure_half(2);
		spi_write(HK_REG_DIV, 8'h00);
		i_checker.expect_clk_low(80);
		spi_write(HK_REG_DIV, 8'h05);
		spi_write(HK_REG_CTRL, 8'h00);
		i_checker.expect_clk_low(80);
		i_checker.end_test("user_clk");

		// Soft reset
		spi_write(HK_REG_CTRL, 8'h02);
		i_checker.wait_rstn(1'b0, 4, n);
		spi_write(HK_REG_CTRL, 8'h00);
		i_checker.wait_rstn(1'b1, 4, n);
		i_checker.end_test("soft_reset");

		// Aborted frames
		spi_write(HK_REG_SCRATCH, 8'h3c);
		spi_frame(HK_OP_WRITE, HK_REG_SCRATCH, 8'hc3, 10);
		spi_frame(HK_OP_READ, HK_REG_SCRATCH, 8'h00, 10);
		i_checker.wait_oenb(1'b1, 4, n);
		spi_read(HK_REG_SCRATCH);
		i_checker.end_test("abort");

		i_checker.report_counts();
		if (i_checker.n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
